//--- Bender.yml
package:
  name: dzcore

sources:
  - include_dirs:
      - .
    files:
      - dzcorePkg.sv
      - dzUcodeRom.sv
      - dzSequencer.sv
      - dzRegFile.sv
      - dzAlu.sv
      - dzBusMaster.sv
      - dzCore.sv
  - target: test
    include_dirs:
      - .
    files:
      - dzcoreTb.sv

//--- dzAlu.sv
`include "dzcore_settings.svh"

module dzAlu (
  input  logic             iClock,
  input  logic             rstN,
  input  dzcorePkg::aluOpT aluOp,
  input  logic             aluEn,
  input  dzcorePkg::byteT  opA,
  input  dzcorePkg::byteT  opB,
  output dzcorePkg::byteT  result,
  output dzcorePkg::flagsT flags
);
  import dzcorePkg::*;

  flagsT      flagsNext;
  logic [8:0] wide;  // bit 8 carries or borrows
  logic [4:0] nibble;

  always_comb
  begin
    flagsNext      = flags;
    flagsNext.zero = '0;
    wide           = '0;
    nibble         = '0;
    result         = opB;
    case (aluOp)
      ALU_ADD:
      begin
        wide        = {1'b0, opA} + {1'b0, opB};
        nibble      = {1'b0, opA[3:0]} + {1'b0, opB[3:0]};
        result      = wide[7:0];
        flagsNext.n = 1'b0;
        flagsNext.h = nibble[4];
        flagsNext.c = wide[8];
      end
      ALU_SUB:
      begin
        wide        = {1'b0, opA} - {1'b0, opB};
        nibble      = {1'b0, opA[3:0]} - {1'b0, opB[3:0]};  // borrow from bit 4
        result      = wide[7:0];
        flagsNext.n = 1'b1;
        flagsNext.h = nibble[4];
        flagsNext.c = wide[8];
      end
      ALU_AND:
      begin
        result      = opA & opB;
        flagsNext.n = 1'b0;
        flagsNext.h = 1'b1;
        flagsNext.c = 1'b0;
      end
      ALU_XOR, ALU_OR:
      begin
        result      = (aluOp == ALU_XOR) ? (opA ^ opB) : (opA | opB);
        flagsNext.n = 1'b0;
        flagsNext.h = 1'b0;
        flagsNext.c = 1'b0;
      end
      // C untouched on INC and DEC
      ALU_INC:
      begin
        result      = opA + 8'd1;
        flagsNext.n = 1'b0;
        flagsNext.h = (result[3:0] == 4'h0);
      end
      ALU_DEC:
      begin
        result      = opA - 8'd1;
        flagsNext.n = 1'b1;
        flagsNext.h = (result[3:0] == 4'hF);
      end
      default: result = opB;  // Moves and loads
    endcase
    if (aluOp != ALU_PASS)
      flagsNext.z = (result == 8'h00);
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      flags <= flagsT'(`DZ_RESET_FLAGS);
    else if (aluEn)
      flags <= flagsNext;
  end

  assert property (@(posedge iClock) disable iff (!rstN)
    flags.zero == 4'h0);

endmodule

//--- dzBusMaster.sv
module dzBusMaster (
  input  logic             iClock,
  input  logic             rstN,
  input  logic             start,
  input  logic             we,
  input  dzcorePkg::addrT  adr,
  input  dzcorePkg::byteT  wrData,
  output logic             done,
  output dzcorePkg::byteT  rdData,
  output dzcorePkg::wbReqT busReq,
  input  dzcorePkg::wbRspT busRsp
);
  import dzcorePkg::*;

  logic cycQ;
  logic weQ;
  addrT adrQ;
  byteT datQ;

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      cycQ <= 1'b0;
      weQ  <= 1'b0;
    end
    else if (start)
    begin
      cycQ <= 1'b1;
      weQ  <= we;
    end
    else if (cycQ && busRsp.ack)
    begin
      cycQ <= 1'b0;  // drops the cycle after ack
      weQ  <= 1'b0;
    end
  end

  always_ff @(posedge iClock)
  begin
    if (start)
    begin
      adrQ <= adr;
      datQ <= wrData;
    end
  end

  assign busReq = '{cyc: cycQ, stb: cycQ, we: weQ, adr: adrQ, dat: datQ};
  assign done   = cycQ && busRsp.ack;
  assign rdData = busRsp.dat;

  assert property (@(posedge iClock) disable iff (!rstN)
    (busReq.stb && !busRsp.ack) |=> ($stable(busReq.adr) && $stable(busReq.dat)));

  // Sequencer waits for done before the next request
  assert property (@(posedge iClock) disable iff (!rstN) start |-> !cycQ);

endmodule

//--- dzCore.sv
module dzCore (
  input  logic             iClock,
  input  logic             rstN,
  output dzcorePkg::wbReqT busReq,
  input  dzcorePkg::wbRspT busRsp,
  output logic             halted
);
  import dzcorePkg::*;

  uopT    uop;
  upcT    upc;
  upcT    flowEntry;
  aluOpT  aluOp;
  byteT   opcode;
  byteT   imm;
  regCtlT regCtl;
  logic   aluEn;
  logic   busStart;
  logic   busWe;
  addrT   busAdr;
  logic   busDone;
  byteT   busRdData;
  addrT   hl;
  byteT   rdA;
  byteT   rdB;
  byteT   aluOpB;
  byteT   aluResult;
  flagsT  flags;

  // Immediate replaces the second read port for LD r,n
  assign aluOpB = (uop.cmd == CMD_LOADIMM) ? imm : rdB;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  dzUcodeRom uRom (
    .upc(upc), .opcode(opcode), .uop(uop), .flowEntry(flowEntry), .aluOp(aluOp)
  );

  dzSequencer uSeq (
    .iClock(iClock), .rstN(rstN), .uop(uop), .flowEntry(flowEntry), .flags(flags),
    .upc(upc), .opcode(opcode), .imm(imm), .regCtl(regCtl), .aluEn(aluEn),
    .busStart(busStart), .busWe(busWe), .busAdr(busAdr), .busDone(busDone),
    .busRdData(busRdData), .hl(hl), .halted(halted)
  );

  // ----------------------------------------
  // Datapath and bus
  // ----------------------------------------
  dzRegFile uRegs (
    .iClock(iClock), .rstN(rstN), .regCtl(regCtl), .wrData(aluResult),
    .rdA(rdA), .rdB(rdB), .hl(hl)
  );

  dzAlu uAlu (
    .iClock(iClock), .rstN(rstN), .aluOp(aluOp), .aluEn(aluEn),
    .opA(rdA), .opB(aluOpB), .result(aluResult), .flags(flags)
  );

  dzBusMaster uBus (
    .iClock(iClock), .rstN(rstN), .start(busStart), .we(busWe), .adr(busAdr),
    .wrData(rdA),  // A on STORE
    .done(busDone), .rdData(busRdData), .busReq(busReq), .busRsp(busRsp)
  );

endmodule

//--- dzRegFile.sv
module dzRegFile (
  input  logic              iClock,
  input  logic              rstN,
  input  dzcorePkg::regCtlT regCtl,
  input  dzcorePkg::byteT   wrData,
  output dzcorePkg::byteT   rdA,
  output dzcorePkg::byteT   rdB,
  output dzcorePkg::addrT   hl
);
  import dzcorePkg::*;

  byteT regQ [7];  // B C D E H L A

  // A sits in the slot after L
  function automatic logic [2:0] slot(regIdT code);
    return (code == REG_A) ? 3'd6 : code;
  endfunction

  function automatic byteT readReg(regIdT code);
    byteT value;
    value = '0;
    if (code != REG_MEM)
      value = regQ[slot(code)];
    return value;
  endfunction

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 7; i++)
      begin
        regQ[i] <= '0;
      end
    end
    else if (regCtl.we && regCtl.wrSel != REG_MEM)
    begin
      regQ[slot(regCtl.wrSel)] <= wrData;
    end
  end

  always_comb
  begin
    rdA = readReg(regCtl.rdA);
    rdB = readReg(regCtl.rdB);
  end

  assign hl  = {regQ[4], regQ[5]};  // Store address

endmodule

//--- dzSequencer.sv
`include "dzcore_settings.svh"

module dzSequencer (
  input  logic              iClock,
  input  logic              rstN,
  input  dzcorePkg::uopT    uop,
  input  dzcorePkg::upcT    flowEntry,
  input  dzcorePkg::flagsT  flags,
  output dzcorePkg::upcT    upc,
  output dzcorePkg::byteT   opcode,
  output dzcorePkg::byteT   imm,
  output dzcorePkg::regCtlT regCtl,
  output logic              aluEn,
  output logic              busStart,
  output logic              busWe,
  output dzcorePkg::addrT   busAdr,
  input  logic              busDone,
  input  dzcorePkg::byteT   busRdData,
  input  dzcorePkg::addrT   hl,
  output logic              halted
);
  import dzcorePkg::*;

  seqStateT state;
  addrT     pc;
  byteT     opcodeQ;
  byteT     jumpLo;
  logic     busPend;  // request issued, waiting for done
  logic     isBusCmd;
  logic     opDone;
  logic     eofHit;
  logic     active;

  assign active   = (state == ST_FETCH) || (state == ST_RUN);
  assign isBusCmd = uop.cmd inside {CMD_FETCH, CMD_READIMM, CMD_JUMPLO, CMD_STORE};
  assign opDone   = isBusCmd ? busDone : 1'b1;
  assign busStart = active && isBusCmd && !busPend;
  assign busWe    = (uop.cmd == CMD_STORE);
  assign busAdr   = busWe ? hl : pc;
  assign halted   = (state == ST_HALTED);

  // New opcode reaches the lookup in the ack cycle
  assign opcode = (state == ST_FETCH && busDone) ? busRdData : opcodeQ;

  always_comb
  begin
    case (uop.eof)
      EOF_END:       eofHit = 1'b1;
      EOF_END_IF_Z:  eofHit = flags.z;
      EOF_END_IF_NZ: eofHit = !flags.z;
      default:       eofHit = 1'b0;
    endcase
  end

  // ----------------------------------------
  // Register file and ALU control
  // ----------------------------------------
  always_comb
  begin
    regCtl.rdA   = (uop.cmd == CMD_ALU && !opcodeQ[7]) ? opcodeQ[5:3] : REG_A;  // INC/DEC
    regCtl.rdB   = opcodeQ[2:0];
    regCtl.wrSel = (uop.cmd == CMD_ALU && opcodeQ[7]) ? REG_A : opcodeQ[5:3];
    regCtl.we    = (state == ST_RUN) && (uop.cmd inside {CMD_MOVE, CMD_LOADIMM, CMD_ALU});
    aluEn        = (state == ST_RUN) && (uop.cmd == CMD_ALU);
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state   <= ST_AFTER_RESET;
      upc     <= FETCH_UPC;
      pc      <= `DZ_RESET_PC;
      busPend <= 1'b0;
    end
    else
    begin
      if (busStart)
        busPend <= 1'b1;
      else if (busDone)
        busPend <= 1'b0;

      case (state)
        ST_AFTER_RESET: state <= ST_FETCH;
        ST_FETCH:
          if (opDone)
          begin
            upc   <= flowEntry;
            state <= ST_RUN;
          end
        ST_RUN:
          if (uop.cmd == CMD_HALT)
            state <= ST_HALTED;
          else if (opDone && eofHit)
            state <= ST_END;
          else if (opDone)
            upc <= upc + 5'd1;
        ST_END:
        begin
          upc   <= FETCH_UPC;
          state <= ST_FETCH;
        end
        default: state <= ST_HALTED;  // until reset
      endcase

      if (active && opDone && uop.cmd == CMD_JUMPHI)
        pc <= {imm, jumpLo};
      else if (active && opDone && uop.incPc)
        pc <= pc + 16'd1;
    end
  end

  // Bus read latches
  always_ff @(posedge iClock)
  begin
    if (active && busDone && uop.cmd == CMD_FETCH)
      opcodeQ <= busRdData;
    if (active && busDone && uop.cmd == CMD_READIMM)
      imm <= busRdData;
    if (active && busDone && uop.cmd == CMD_JUMPLO)
      jumpLo <= busRdData;
  end

  // A flow that keeps stepping must stay inside the ROM
  assert property (@(posedge iClock) disable iff (!rstN)
    (state == ST_RUN && opDone && !eofHit && uop.cmd != CMD_HALT)
      |-> (int'(upc) + 1 < `DZ_UCODE_DEPTH));

endmodule

//--- dzUcodeRom.sv
`include "dzcore_settings.svh"

module dzUcodeRom (
  input  dzcorePkg::upcT   upc,
  input  dzcorePkg::byteT  opcode,
  output dzcorePkg::uopT   uop,
  output dzcorePkg::upcT   flowEntry,
  output dzcorePkg::aluOpT aluOp
);
  import dzcorePkg::*;

  localparam upcT FLOW_NOP     = 5'd1;
  localparam upcT FLOW_MOVE    = 5'd2;
  localparam upcT FLOW_LOADIMM = 5'd3;
  localparam upcT FLOW_ALU     = 5'd5;
  localparam upcT FLOW_INCDEC  = 5'd6;
  localparam upcT FLOW_STORE   = 5'd7;
  localparam upcT FLOW_JP      = 5'd8;
  localparam upcT FLOW_JPZ     = 5'd11;
  localparam upcT FLOW_JPNZ    = 5'd14;
  localparam upcT FLOW_HALT    = 5'd17;

  uopT rom [`DZ_UCODE_DEPTH];

  // ----------------------------------------
  // Flow table
  // ----------------------------------------
  always_comb
  begin
    for (int i = 0; i < `DZ_UCODE_DEPTH; i++)
    begin
      rom[i] = '{CMD_NOP, EOF_END, 1'b0};
    end
    rom[FETCH_UPC]        = '{CMD_FETCH, EOF_CONTINUE, 1'b1};
    rom[FLOW_NOP]         = '{CMD_NOP, EOF_END, 1'b0};
    rom[FLOW_MOVE]        = '{CMD_MOVE, EOF_END, 1'b0};
    rom[FLOW_LOADIMM]     = '{CMD_READIMM, EOF_CONTINUE, 1'b1};
    rom[FLOW_LOADIMM + 1] = '{CMD_LOADIMM, EOF_END, 1'b0};
    rom[FLOW_ALU]         = '{CMD_ALU, EOF_END, 1'b0};
    rom[FLOW_INCDEC]      = '{CMD_ALU, EOF_END, 1'b0};
    rom[FLOW_STORE]       = '{CMD_STORE, EOF_END, 1'b0};
    // High byte goes through the immediate latch
    rom[FLOW_JP]          = '{CMD_JUMPLO, EOF_CONTINUE, 1'b1};
    rom[FLOW_JP + 1]      = '{CMD_READIMM, EOF_CONTINUE, 1'b1};
    rom[FLOW_JP + 2]      = '{CMD_JUMPHI, EOF_END, 1'b0};
    rom[FLOW_JPZ]         = '{CMD_JUMPLO, EOF_CONTINUE, 1'b1};
    rom[FLOW_JPZ + 1]     = '{CMD_READIMM, EOF_END_IF_NZ, 1'b1};  // not taken
    rom[FLOW_JPZ + 2]     = '{CMD_JUMPHI, EOF_END, 1'b0};
    rom[FLOW_JPNZ]        = '{CMD_JUMPLO, EOF_CONTINUE, 1'b1};
    rom[FLOW_JPNZ + 1]    = '{CMD_READIMM, EOF_END_IF_Z, 1'b1};
    rom[FLOW_JPNZ + 2]    = '{CMD_JUMPHI, EOF_END, 1'b0};
    rom[FLOW_HALT]        = '{CMD_HALT, EOF_END, 1'b0};
  end

  assign uop = rom[upc];

  // ----------------------------------------
  // Opcode lookup
  // ----------------------------------------
  always_comb
  begin
    flowEntry = FLOW_NOP;
    aluOp     = ALU_PASS;
    casez (opcode)
      8'h76: flowEntry = FLOW_HALT;
      8'h77: flowEntry = FLOW_STORE;
      8'hC3: flowEntry = FLOW_JP;
      8'hCA: flowEntry = FLOW_JPZ;
      8'hC2: flowEntry = FLOW_JPNZ;
      8'b01??????:
        if (opcode[5:3] != REG_MEM && opcode[2:0] != REG_MEM)
          flowEntry = FLOW_MOVE;
      8'b00???110:
        if (opcode[5:3] != REG_MEM)
          flowEntry = FLOW_LOADIMM;
      8'b00???10?:
        if (opcode[5:3] != REG_MEM)
        begin
          flowEntry = FLOW_INCDEC;
          aluOp     = opcode[0] ? ALU_DEC : ALU_INC;
        end
      8'b10??????:
        if (opcode[2:0] != REG_MEM)
        begin
          flowEntry = FLOW_ALU;
          case (opcode[5:3])
            3'b000:  aluOp = ALU_ADD;
            3'b010:  aluOp = ALU_SUB;
            3'b100:  aluOp = ALU_AND;
            3'b101:  aluOp = ALU_XOR;
            3'b110:  aluOp = ALU_OR;
            default: flowEntry = FLOW_NOP;  // ADC, SBC, CP not kept
          endcase
        end
      default: flowEntry = FLOW_NOP;
    endcase
  end

endmodule

//--- dzcore.f
+incdir+.
dzcorePkg.sv
dzUcodeRom.sv
dzSequencer.sv
dzRegFile.sv
dzAlu.sv
dzBusMaster.sv
dzCore.sv
dzcoreTb.sv

//--- dzcorePkg.sv
package dzcorePkg;

  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;
  typedef logic [2:0]  regIdT;  // B C D E H L (HL) A
  typedef logic [4:0]  upcT;

  localparam regIdT REG_MEM = 3'b110;
  localparam regIdT REG_A   = 3'b111;

  // Every instruction starts at the fetch word
  localparam upcT FETCH_UPC = 5'd0;

  typedef enum logic [3:0] {
    CMD_NOP,
    CMD_FETCH,    // opcode read at PC
    CMD_READIMM,  // operand read at PC
    CMD_LOADIMM,
    CMD_MOVE,
    CMD_ALU,
    CMD_STORE,    // A to (HL)
    CMD_JUMPLO,
    CMD_JUMPHI,
    CMD_HALT
  } uCmdT;

  typedef enum logic [1:0] {
    EOF_CONTINUE,
    EOF_END,
    EOF_END_IF_Z,
    EOF_END_IF_NZ
  } eofT;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR, ALU_INC, ALU_DEC, ALU_PASS
  } aluOpT;

  typedef enum logic [2:0] {
    ST_AFTER_RESET, ST_FETCH, ST_RUN, ST_END, ST_HALTED
  } seqStateT;

  typedef struct packed {
    uCmdT cmd;
    eofT  eof;
    logic incPc;
  } uopT;

  // Same bit order as the classic F register
  typedef struct packed {
    logic       z;
    logic       n;
    logic       h;
    logic       c;
    logic [3:0] zero;
  } flagsT;

  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    addrT adr;
    byteT dat;
  } wbReqT;

  typedef struct packed {
    logic ack;
    byteT dat;
  } wbRspT;

  typedef struct packed {
    regIdT rdA;
    regIdT rdB;
    regIdT wrSel;
    logic  we;
  } regCtlT;

endpackage

//--- dzcore_tests.svh
`ifndef DZCORE_TESTS_SVH
`define DZCORE_TESTS_SVH

localparam int NUM_TESTS  = 6;
localparam int PROG_BYTES = 24;
localparam int MAX_STORES = 4;

typedef logic [63:0] nameT;  // Eight ASCII characters

typedef struct packed {
  nameT                  name;
  byteT [0:PROG_BYTES-1] prog;  // Loaded at address 0
  logic [2:0]            storeCount;
  addrT [0:MAX_STORES-1] stAdr;  // In bus order
  byteT [0:MAX_STORES-1] stDat;
} testRowT;

// ----------------------------------------
// Programs and expected store streams
// ----------------------------------------
localparam testRowT TESTS [NUM_TESTS] = '{
  // Constant walks B C D E L A, then a second constant
  '{name: "loadmove",
    prog: {64'h06A5_4851_5A6B_7D26, 64'h802E_1077_2E11_3E3C, 64'h7776_0000_0000_0000},
    storeCount: 3'd2, stAdr: 64'h8010_8011_0000_0000, stDat: 32'hA53C_0000},
  // 70+95 wraps to 05, 05-05 gives zero so JP NZ falls through
  '{name: "addsub_z",
    prog: {64'h3E70_0695_8026_9077, 64'h0E05_91C2_1200_2E01, 64'h7776_2E02_7776_0000},
    storeCount: 3'd2, stAdr: 64'h9000_9001_0000_0000, stDat: 32'h0500_0000},
  // AND to 30, XOR A,A to zero, OR to 3C skips a JP Z onto HALT
  '{name: "logic_zf",
    prog: {64'h3EF0_063C_A026_A0CA, 64'h1600_77AF_CA10_0076, 64'hB0CA_1700_2E01_7776},
    storeCount: 3'd2, stAdr: 64'hA000_A001_0000_0000, stDat: 32'h303C_0000},
  // Borrowing SUB, INC A to zero, L steps FF then 00
  '{name: "incdec_c",
    prog: {64'h3E10_0611_903C_C214, 64'h0026_B02D_0478_772C, 64'hCA15_0076_763D_7776},
    storeCount: 3'd2, stAdr: 64'hB0FF_B000_0000_0000, stDat: 32'h1211_0000},
  // Unkept opcodes, then a store hidden behind HALT
  '{name: "nop_halt",
    prog: {64'h3E42_0601_88B8_0334, 64'h8670_0026_C077_762E, 64'h0177_7600_0000_0000},
    storeCount: 3'd1, stAdr: 64'hC000_0000_0000_0000, stDat: 32'h4200_0000},
  // Three laps of a DEC C loop, then JP nn to a marker
  '{name: "jumploop",
    prog: {64'h26D0_0E03_3E07_772C, 64'h3C0D_C206_00C3_1200, 64'h7676_3EE5_7776_0000},
    storeCount: 3'd4, stAdr: 64'hD000_D001_D002_D003, stDat: 32'h0708_09E5}
};

`endif

//--- dzcoreTb.sv
`include "dzcore_settings.svh"

module dzcoreTb;
  timeunit 1ns;
  timeprecision 1ps;
  import dzcorePkg::*;

  `include "dzcore_tests.svh"

  // Generous bound over all rows together
  localparam int CYCLE_LIMIT = 64 * PROG_BYTES * NUM_TESTS;

  logic        iClock = 1'b0;
  logic        rstN = 1'b0;
  wbReqT       busReq;
  wbRspT       busRsp = '0;
  logic        halted;

  byteT        mem [65536];
  addrT        storeAdr [$];
  byteT        storeDat [$];
  int unsigned lcgState = 42;
  logic        pending = 1'b0;  // Request seen, ack not yet given
  int          waitLeft = 0;
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;

  dzCore UUT (
    .iClock(iClock), .rstN(rstN), .busReq(busReq), .busRsp(busRsp), .halted(halted)
  );

  always #20 iClock = ~iClock;

  function automatic int unsigned nextAckDelay();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return (lcgState >> 16) % 4;  // 0 to 3 wait cycles
  endfunction

  // ----------------------------------------
  // Wishbone memory model
  // ----------------------------------------
  always @(posedge iClock)
  begin
    if (!rstN)
    begin
      busRsp.ack <= 1'b0;
      pending = 1'b0;
    end
    else if (busRsp.ack)
    begin
      busRsp.ack <= 1'b0;  // Master drops cyc at this edge
      pending = 1'b0;
    end
    else if (busReq.cyc && busReq.stb)
    begin
      if (!pending)
      begin
        pending = 1'b1;
        waitLeft = nextAckDelay();
      end
      if (waitLeft == 0)
      begin
        busRsp.ack <= 1'b1;
        busRsp.dat <= mem[busReq.adr];
        if (busReq.we)
        begin
          mem[busReq.adr] = busReq.dat;
          storeAdr.push_back(busReq.adr);
          storeDat.push_back(busReq.dat);
        end
      end
      else
        waitLeft--;
    end
  end

  always @(posedge iClock)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("Timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic checkAddr(input nameT test, input int idx, input addrT expected,
                           input addrT actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s store %0d address: expected %h, actual %h",
               test, idx, expected, actual);
    end
  endtask

  task automatic checkData(input nameT test, input int idx, input byteT expected,
                           input byteT actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("ERROR %s store %0d data: expected %h, actual %h",
               test, idx, expected, actual);
    end
  endtask

  task automatic checkCount(input nameT test, input int expected, input int actual);
    checks++;
    if (actual != expected)
    begin
      errors++;
      $display("ERROR %s store count: expected %0d, actual %0d", test, expected, actual);
    end
  endtask

  task automatic runTest(input testRowT row);
    @(posedge iClock);
    rstN <= 1'b0;
    for (int i = 0; i < PROG_BYTES; i++)
    begin
      mem[i] = row.prog[i];
    end
    storeAdr.delete();
    storeDat.delete();
    repeat (3) @(posedge iClock);
    rstN <= 1'b1;
    @(posedge iClock);
    if (busReq.cyc || busReq.stb || busReq.we || halted)
    begin
      errors++;
      $display("ERROR %s: bus or halted output not idle right after reset", row.name);
    end
    while (!busReq.cyc)
      @(posedge iClock);
    checkAddr(row.name, 0, `DZ_RESET_PC, busReq.adr);  // First fetch
    while (!halted)
      @(posedge iClock);
    repeat (4) @(posedge iClock);  // Nothing may follow HALT
    checkCount(row.name, row.storeCount, storeAdr.size());
    for (int s = 0; s < storeAdr.size() && s < MAX_STORES; s++)
    begin
      checkAddr(row.name, s, row.stAdr[s], storeAdr[s]);
      checkData(row.name, s, row.stDat[s], storeDat[s]);
    end
  endtask

  initial
  begin
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      runTest(TESTS[t]);
    end
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- dzcore_settings.svh
`ifndef DZCORE_SETTINGS_SVH
`define DZCORE_SETTINGS_SVH

// ----------------------------------------
// Reset values
// ----------------------------------------

// First opcode fetch address
`define DZ_RESET_PC 16'h0000

// Z, H and C set out of reset
`define DZ_RESET_FLAGS 8'hB0

// ----------------------------------------
// Microcode
// ----------------------------------------

`define DZ_UCODE_DEPTH 32

`endif
